/* common/av_out_defs.svh */
////////////////////////////////////////
// av output constants
// raster geometry, sync position, scaler slot word and i2s division
////////////////////////////////////////
`ifndef AV_OUT_DEFS_SVH
`define AV_OUT_DEFS_SVH

// raster, pixels per line and lines per frame
`define AV_H_TOTAL      800
`define AV_V_TOTAL      1024

// active window and its offset into the raster
`define AV_H_ACTIVE     400
`define AV_H_BPORCH     10
`define AV_V_ACTIVE     360
`define AV_V_BPORCH     10

// hsync sits a few pixels in, clear of vsync
`define AV_HS_X         3

// counter width, covers both totals
`define AV_COORD_W      10

// scaler slot number, lands in rgb[23:13]
`define AV_SLOT_INDEX   1

// i2s, mclk / 4 gives sclk, 32 sclk per channel
`define AV_SCLK_DIV_W   2
`define AV_I2S_CH_BITS  32

`endif

/* common/av_out_pkg.sv */
////////////////////////////////////////
// av output types
// vector types shared by the video path
////////////////////////////////////////
`default_nettype none

`include "av_out_defs.svh"

package av_out_pkg;

    // pixel or line position
    typedef logic [`AV_COORD_W-1:0] coord_t;

    // source colour from the pixel generator
    // red in [11:8], green in [7:4], blue in [3:0]
    typedef logic [11:0] rgb12_t;

    // scaler colour, 8 bits a channel
    // red in [23:16], green in [15:8], blue in [7:0]
    typedef logic [23:0] rgb24_t;

    // free-running frame count, wraps
    typedef logic [15:0] frame_count_t;

endpackage

`default_nettype wire

/* project.f */
+incdir+common
common/av_out_pkg.sv
video/video_timing.sv
video/pixel_output.sv
src/i2s_silence_gen.sv
src/av_out_top.sv
verification/tb_av_out_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the av output testbench with verilator
# pass or fail comes from the simulation log

cd "$(dirname "$0")" || exit 1

top=tb_av_out_top
log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module "$top" -f project.f -o "sim_$top" \
    && "./obj_dir/sim_$top" > "$log" 2>&1 \
    || { echo "build or simulation run failed, see $log"; exit 1; }

grep -qx "All checks passed" "$log" \
    && { echo "PASS"; exit 0; } \
    || { echo "FAIL"; tail -n 20 "$log"; exit 1; }

/* src/av_out_top.sv */
////////////////////////////////////////
// av output top
// video timing, pixel output and silent i2s
////////////////////////////////////////
`default_nettype none

module av_out_top (
    input  logic                     audgen_mclk,
    input  logic                     reset_n,
    input  av_out_pkg::rgb12_t       pixel_rgb12,
    // video to scaler
    output av_out_pkg::rgb24_t       video_rgb,
    output logic                     video_de,
    output logic                     video_vs,
    output logic                     video_hs,
    output av_out_pkg::frame_count_t frame_count,
    // audio
    output logic                     audio_sclk,
    output logic                     audio_lrck,
    output logic                     audio_dac
);

    // timing decodes into the output stage
    logic frame_start;
    logic line_start;
    logic active;

    ////////////////////////////////////////
    // video
    ////////////////////////////////////////

    video_timing u_video_timing (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n),
        .frame_start (frame_start),
        .line_start  (line_start),
        .active      (active),
        .frame_count (frame_count)
    );

    pixel_output u_pixel_output (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n),
        .frame_start (frame_start),
        .line_start  (line_start),
        .active      (active),
        .pixel_rgb12 (pixel_rgb12),
        .video_rgb   (video_rgb),
        .video_de    (video_de),
        .video_vs    (video_vs),
        .video_hs    (video_hs)
    );

    ////////////////////////////////////////
    // audio
    ////////////////////////////////////////

    i2s_silence_gen u_i2s_silence_gen (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n),
        .audio_sclk  (audio_sclk),
        .audio_lrck  (audio_lrck)
    );

    // silent stream
    assign audio_dac = 1'b0;

endmodule

`default_nettype wire

/* src/i2s_silence_gen.sv */
////////////////////////////////////////
// i2s silence generator
// bit clock and word clock for a silent stream
////////////////////////////////////////
`default_nettype none

`include "av_out_defs.svh"

module i2s_silence_gen (
    input  logic audgen_mclk,
    input  logic reset_n,
    output logic audio_sclk,
    output logic audio_lrck
);

    localparam int BIT_W = $clog2(`AV_I2S_CH_BITS);

    logic [`AV_SCLK_DIV_W-1:0] sclk_div;
    logic [BIT_W-1:0]          bit_cnt;
    logic                      div_wrap;
    logic                      lrck_toggle;

    // sclk is the divider msb
    assign audio_sclk = sclk_div[`AV_SCLK_DIV_W-1];
    // divider rolls over where sclk falls
    assign div_wrap   = &sclk_div;

    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            sclk_div    <= '0;
            bit_cnt     <= '0;
            lrck_toggle <= 1'b0;
            audio_lrck  <= 1'b0;
        end else begin
            sclk_div <= sclk_div + 1'b1;
            // one count per sclk falling edge
            if (div_wrap) begin
                bit_cnt <= bit_cnt + 1'b1;
            end
            // end of channel, flip lrck on the next mclk
            lrck_toggle <= div_wrap && (bit_cnt == BIT_W'(`AV_I2S_CH_BITS - 1));
            if (lrck_toggle) begin
                audio_lrck <= !audio_lrck;
            end
        end
    end

endmodule

`default_nettype wire

/* verification/av_out_input.txt */
// column 1: pixel colour, 12-bit rgb, 4 bits a channel
// column 2: expected 24-bit video_rgb, one row per scan line
f00 f00000
0f0 00f000
00f 0000f0
fff f0f0f0
123 102030
a5c a050c0
7e1 70e010
3b9 30b090
c48 c04080
6d2 60d020
9a6 90a060
2f7 20f070
e3d e030d0
58b 5080b0
4c5 40c050
8e4 80e040

/* verification/tb_av_out_top.sv */
////////////////////////////////////////
// av output testbench
// reads line colours from a data file
// checks sync, enable, colour, slot word and i2s timing
////////////////////////////////////////
`default_nettype none

`include "av_out_defs.svh"

module tb_av_out_top;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 16;
    localparam int LINE_CYCLES  = `AV_H_TOTAL;
    localparam int FRAME_CYCLES = `AV_H_TOTAL * `AV_V_TOTAL;
    // two whole frames plus the vsync that closes the second
    localparam int RUN_CYCLES   = 2 * FRAME_CYCLES + 8;
    // a quarter on top of the run gives about 2.5 frames
    localparam int WATCHDOG_NS  = (RESET_CYCLES + RUN_CYCLES) * CLK_PERIOD * 5 / 4;
    // lrck half period in mclk cycles
    localparam int LRCK_HALF    = (1 << `AV_SCLK_DIV_W) * `AV_I2S_CH_BITS;
    localparam logic [23:0] SLOT_WORD = 24'h002000;

    logic                     audgen_mclk;
    logic                     reset_n;
    av_out_pkg::rgb12_t       pixel_rgb12;
    av_out_pkg::rgb24_t       video_rgb;
    logic                     video_de;
    logic                     video_vs;
    logic                     video_hs;
    av_out_pkg::frame_count_t frame_count;
    logic                     audio_sclk;
    logic                     audio_lrck;
    logic                     audio_dac;

    // colour in even entries and expected rgb in odd ones
    logic [23:0] stim [0:31];
    logic [3:0]  drive_row = '0;
    logic [3:0]  applied_row = '0;
    logic [23:0] exp_d1 = '0;
    logic [23:0] exp_d2 = '0;
    logic [15:0] fc_last = '0;
    logic        vs_d = 1'b0;
    logic        hs_d = 1'b0;
    logic        de_d = 1'b0;
    logic        lrck_d = 1'b0;
    logic        sclk_d1 = 1'b0;
    logic        sclk_d2 = 1'b0;
    logic        change_armed = 1'b0;
    int seed = 32'ha97b;
    int errors = 0;
    int checks = 0;
    int sample_cnt = 0;
    int since_vs = -1;
    int since_hs = -1;
    int since_lrck = -1;
    int sclk_run = 1;
    int frames_seen = 0;
    int hs_in_frame = 0;
    int cur_line = 0;
    int de_lines = 0;
    int de_run = 0;
    int lines_driven = 0;
    int change_line;
    int change_offset;

    av_out_top u_dut (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n),
        .pixel_rgb12 (pixel_rgb12),
        .video_rgb   (video_rgb),
        .video_de    (video_de),
        .video_vs    (video_vs),
        .video_hs    (video_hs),
        .frame_count (frame_count),
        .audio_sclk  (audio_sclk),
        .audio_lrck  (audio_lrck),
        .audio_dac   (audio_dac)
    );

    ////////////////////////////////////////
    // clock, stimulus and watchdog
    ////////////////////////////////////////

    initial begin
        audgen_mclk = 1'b0;
        forever #(CLK_PERIOD / 2) audgen_mclk = ~audgen_mclk;
    end

    // row picked at the last falling edge goes out here
    always @(posedge audgen_mclk) begin
        pixel_rgb12 <= stim[{drive_row, 1'b0}][11:0];
        applied_row <= drive_row;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: run did not reach its end within %0d ns", WATCHDOG_NS);
        $display("checks %0d, errors %0d", checks, errors);
        $display("Checks failed");
        $finish;
    end

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] want);
        checks++;
        assert (got == want) else begin
            errors++;
            $display("mismatch at %0d ns: %s is %0h, expected %0h", $time, what, got, want);
        end
    endtask

    // new colour row per line with rotation first and random reuse after
    task automatic next_line_colour();
        if (lines_driven < 16) begin
            drive_row = 4'(lines_driven);
        end else begin
            drive_row = 4'($random(seed));
        end
        lines_driven++;
        // mid-line change on one line of the first frame
        if (frames_seen == 1 && cur_line == change_line) begin
            change_armed = 1'b1;
        end
    endtask

    task automatic check_idle_outputs();
        check_value("video_rgb after reset", 32'(video_rgb), 32'd0);
        check_value("syncs and enable after reset", 32'({video_vs, video_hs, video_de}), 32'd0);
        check_value("frame_count after reset", 32'(frame_count), 32'd0);
        check_value("audio after reset", 32'({audio_sclk, audio_lrck, audio_dac}), 32'd0);
    endtask

    task automatic check_video();
        if (since_vs >= 0) since_vs++;
        if (since_hs >= 0) since_hs++;
        // vsync, frame count and lines per frame
        if (video_vs) begin
            check_value("video_vs width", 32'(vs_d), 32'd0);
            if (since_vs >= 0) check_value("vsync period", since_vs, FRAME_CYCLES);
            check_value("frame_count step", 32'(frame_count), 32'(fc_last + 16'd1));
            if (frames_seen > 0) check_value("active lines per frame", de_lines, `AV_V_ACTIVE);
            frames_seen++;
            since_vs = 0;
            de_lines = 0;
            hs_in_frame = 0;
        end else begin
            check_value("frame_count hold", 32'(frame_count), 32'(fc_last));
        end
        fc_last = frame_count;
        // hsync three cycles behind vsync
        if (since_vs == 3) check_value("hsync after vsync", 32'(video_hs), 32'd1);
        if (video_hs) begin
            check_value("video_hs width", 32'(hs_d), 32'd0);
            if (since_hs >= 0) check_value("hsync period", since_hs, LINE_CYCLES);
            since_hs = 0;
            cur_line = hs_in_frame;
            hs_in_frame++;
            next_line_colour();
        end
        if (video_de) begin
            if (!de_d) begin
                check_value("de start after hsync", since_hs, `AV_H_BPORCH - `AV_HS_X);
                assert (cur_line >= `AV_V_BPORCH) else begin
                    errors++;
                    $display("video_de seen on line %0d, inside vertical blanking", cur_line);
                end
                de_lines++;
                de_run = 0;
            end
            de_run++;
            // colour lags the drive by two edges
            if (de_run >= 3) check_value("video_rgb in window", 32'(video_rgb), 32'(exp_d2));
            if (change_armed && de_run == change_offset) begin
                drive_row = drive_row + 4'd5;
                change_armed = 1'b0;
            end
        end else if (de_d) begin
            check_value("video_de run length", de_run, `AV_H_ACTIVE);
            check_value("slot word after line", 32'(video_rgb), 32'(SLOT_WORD));
        end else begin
            check_value("video_rgb blank", 32'(video_rgb), 32'd0);
        end
    endtask

    task automatic check_audio();
        // every sclk level lasts two mclk
        if (audio_sclk != sclk_d1) begin
            check_value("sclk half period", sclk_run, 2);
            sclk_run = 1;
        end else begin
            sclk_run++;
        end
        if (since_lrck >= 0) since_lrck++;
        if (audio_lrck != lrck_d) begin
            check_value("lrck one cycle after sclk fall", 32'({sclk_d2, sclk_d1}), 32'b10);
            if (since_lrck >= 0) check_value("lrck half period", since_lrck, LRCK_HALF);
            since_lrck = 0;
        end
        check_value("audio_dac", 32'(audio_dac), 32'd0);
    endtask

    // outputs are stable on the falling edge
    always @(negedge audgen_mclk) begin
        if (reset_n) begin
            if (sample_cnt == 0) begin
                check_idle_outputs();
            end else begin
                check_video();
                check_audio();
            end
            exp_d2 = exp_d1;
            exp_d1 = stim[{applied_row, 1'b1}];
            vs_d = video_vs;
            hs_d = video_hs;
            de_d = video_de;
            lrck_d = audio_lrck;
            sclk_d2 = sclk_d1;
            sclk_d1 = audio_sclk;
            sample_cnt++;
        end
    end

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////

    initial begin
        reset_n     = 1'b0;
        pixel_rgb12 = '0;
        $readmemh("verification/av_out_input.txt", stim);
        change_line   = `AV_V_BPORCH + int'($unsigned($random(seed)) % `AV_V_ACTIVE);
        change_offset = 20 + int'($unsigned($random(seed)) % 360);
        repeat (RESET_CYCLES) @(posedge audgen_mclk);
        reset_n <= 1'b1;
        while (sample_cnt < RUN_CYCLES) @(negedge audgen_mclk);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* video/pixel_output.sv */
////////////////////////////////////////
// pixel output
// registered sync, data enable and colour to the scaler
// inserts the slot-select word after each active line
////////////////////////////////////////
`default_nettype none

`include "av_out_defs.svh"

module pixel_output (
    input  logic                audgen_mclk,
    input  logic                reset_n,
    input  logic                frame_start,
    input  logic                line_start,
    input  logic                active,
    input  av_out_pkg::rgb12_t  pixel_rgb12,
    output av_out_pkg::rgb24_t  video_rgb,
    output logic                video_de,
    output logic                video_vs,
    output logic                video_hs
);

    import av_out_pkg::*;

    // slot command, index in [23:13], rest zero
    localparam rgb24_t SLOT_WORD = {11'(`AV_SLOT_INDEX), 13'd0};

    rgb12_t pixel_q;
    rgb24_t pixel_exp;
    logic   line_end;

    ////////////////////////////////////////
    // colour path
    ////////////////////////////////////////

    // first colour stage
    always_ff @(posedge audgen_mclk) begin
        pixel_q <= pixel_rgb12;
    end

    // each nibble into the top of its byte
    assign pixel_exp = {pixel_q[11:8], 4'h0,
                        pixel_q[7:4],  4'h0,
                        pixel_q[3:0],  4'h0};

    // window just closed, video_de still holds last cycle's enable
    assign line_end = !active && video_de;

    ////////////////////////////////////////
    // output registers
    ////////////////////////////////////////

    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            video_vs  <= 1'b0;
            video_hs  <= 1'b0;
            video_de  <= 1'b0;
            video_rgb <= '0;
        end else begin
            // syncs and enable trail their decodes by one
            video_vs <= frame_start;
            video_hs <= line_start;
            video_de <= active;

            // black unless in window or at line end
            if (active) begin
                video_rgb <= pixel_exp;
            end else if (line_end) begin
                video_rgb <= SLOT_WORD;
            end else begin
                video_rgb <= '0;
            end
        end
    end

endmodule

`default_nettype wire

/* video/video_timing.sv */
////////////////////////////////////////
// video timing
// pixel, line and frame counters
// decodes frame start, sync position and active window
////////////////////////////////////////
`default_nettype none

`include "av_out_defs.svh"

module video_timing (
    input  logic                     audgen_mclk,
    input  logic                     reset_n,
    output logic                     frame_start,
    output logic                     line_start,
    output logic                     active,
    output av_out_pkg::frame_count_t frame_count
);

    import av_out_pkg::*;

    // last count before wrap
    localparam coord_t H_LAST  = coord_t'(`AV_H_TOTAL - 1);
    localparam coord_t V_LAST  = coord_t'(`AV_V_TOTAL - 1);
    // window edges, first inside and first outside
    localparam coord_t H_FIRST = coord_t'(`AV_H_BPORCH);
    localparam coord_t H_END   = coord_t'(`AV_H_BPORCH + `AV_H_ACTIVE);
    localparam coord_t V_FIRST = coord_t'(`AV_V_BPORCH);
    localparam coord_t V_END   = coord_t'(`AV_V_BPORCH + `AV_V_ACTIVE);
    localparam coord_t HS_X    = coord_t'(`AV_HS_X);

    coord_t x_count;
    coord_t y_count;
    logic   h_window;
    logic   v_window;

    ////////////////////////////////////////
    // counters
    ////////////////////////////////////////

    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            x_count     <= '0;
            y_count     <= '0;
            frame_count <= '0;
        end else begin
            // pixel counter, line advances on wrap
            if (x_count == H_LAST) begin
                x_count <= '0;
                if (y_count == V_LAST) begin
                    y_count <= '0;
                end else begin
                    y_count <= y_count + coord_t'(1);
                end
            end else begin
                x_count <= x_count + coord_t'(1);
            end
            // one per frame, leaving the origin
            if (frame_start) begin
                frame_count <= frame_count + 16'd1;
            end
        end
    end

    ////////////////////////////////////////
    // decodes
    ////////////////////////////////////////

    // origin of the raster
    assign frame_start = (x_count == '0) && (y_count == '0);
    // hsync position on every line
    assign line_start  = (x_count == HS_X);

    // active window
    assign h_window = (x_count >= H_FIRST) && (x_count < H_END);
    assign v_window = (y_count >= V_FIRST) && (y_count < V_END);
    assign active   = h_window && v_window;

endmodule

`default_nettype wire
